// ==== verilog/rv_csr_pkg.sv ====
// RV32 machine-mode CSR map only; no supervisor or user CSRs, no counters, no delegation.
package rv_csr_pkg;

    // Data word of the 32-bit hart.
    typedef logic [31:0] xlen_word_t;
    // Halfword-aligned PC, bit 0 is implied zero.
    typedef logic [31:1] pc_t;
    // Word-aligned trap vector base.
    typedef logic [31:2] tvec_t;
    // Trap or interrupt number.
    typedef logic [4:0] cause_t;
    // CSR address.
    typedef logic [11:0] csr_addr_t;
    // One bit per interrupt number.
    typedef logic [31:0] irq_vec_t;

    // Machine trap setup.
    localparam csr_addr_t MSTATUS    = 12'h300;
    localparam csr_addr_t MISA       = 12'h301;
    localparam csr_addr_t MEDELEG    = 12'h302;
    localparam csr_addr_t MIDELEG    = 12'h303;
    localparam csr_addr_t MIE        = 12'h304;
    localparam csr_addr_t MTVEC      = 12'h305;
    localparam csr_addr_t MSTATUSH   = 12'h310;
    // Machine trap handling.
    localparam csr_addr_t MSCRATCH   = 12'h340;
    localparam csr_addr_t MEPC       = 12'h341;
    localparam csr_addr_t MCAUSE     = 12'h342;
    localparam csr_addr_t MTVAL      = 12'h343;
    localparam csr_addr_t MIP        = 12'h344;
    // Machine identification, read-only space.
    localparam csr_addr_t MVENDORID  = 12'hf11;
    localparam csr_addr_t MARCHID    = 12'hf12;
    localparam csr_addr_t MIMPID     = 12'hf13;
    localparam csr_addr_t MHARTID    = 12'hf14;
    localparam csr_addr_t MCONFIGPTR = 12'hf15;

    // Interrupt enable bits in mstatus.
    localparam int mstatus_mie_bit  = 3;
    localparam int mstatus_mpie_bit = 7;

    // Machine timer interrupt number.
    localparam cause_t timer_irq_num = 5'd7;
    // First platform interrupt, lines 16 up to 31.
    localparam int ext_irq_lo = 16;

endpackage

// ==== verilog/impl_id_pkg.sv ====
// Identity of this implementation; marchid is fixed and must stay readable from M-mode.
package impl_id_pkg;

    // Registered open-source architecture ID.
    localparam logic [31:0] arch_id = 32'd37;

    // Semantic version, packed into mimpid.
    localparam logic [7:0] ver_major = 8'd1;
    localparam logic [3:0] ver_minor = 4'd4;
    localparam logic [3:0] ver_patch = 4'd0;

    // Extension letters in misa.
    localparam int misa_a_bit = 0;
    localparam int misa_c_bit = 2;
    localparam int misa_i_bit = 8;
    localparam int misa_m_bit = 12;

    // MXL field for a 32-bit hart.
    localparam logic [1:0] misa_mxl_32 = 2'b01;

endpackage

// ==== verilog/machine_csrs.sv ====
// Trap entry wins over a CSR write, which wins over MRET; misa bits only for built extensions.
module machine_csrs
    import rv_csr_pkg::*;
    import impl_id_pkg::*;
#(
    parameter xlen_word_t hartid      = 32'h0,
    parameter bit         misa_we     = 1'b1,
    parameter bit         has_m       = 1'b1,
    parameter bit         has_a       = 1'b1,
    parameter bit         has_c       = 1'b1,
    parameter int         div_latency = 2
) (
    input  logic       clk,
    input  logic       rst,
    input  csr_addr_t  csr_addr,
    input  logic       csr_we,
    input  xlen_word_t csr_wdata,
    input  logic       take_irq,
    input  logic       take_trap,
    input  cause_t     take_cause,
    input  pc_t        take_epc,
    input  logic       mret,
    input  irq_vec_t   irq_pending,
    output xlen_word_t csr_rdata,
    output logic       csr_exists,
    output logic       csr_rdonly,
    output logic       mstatus_mie,
    output irq_vec_t   mie,
    output tvec_t      tvec,
    output pc_t        ret_epc,
    output xlen_word_t misa
);
    // Held state.
    logic       mstatus_mpie;
    logic       mcause_int;
    cause_t     mcause_no;
    xlen_word_t mscratch;
    pc_t        mepc;
    tvec_t      mtvec;
    logic       misa_a;
    logic       misa_c;
    logic       misa_m;

    // Views assembled from the state.
    xlen_word_t mstatus;
    xlen_word_t mimpid;
    irq_vec_t   mip;

    always_comb begin
        mstatus = '0;
        mstatus[mstatus_mie_bit]  = mstatus_mie;
        mstatus[mstatus_mpie_bit] = mstatus_mpie;
    end

    always_comb begin
        misa = '0;
        misa[31:30] = misa_mxl_32;
        // Base integer set is always on.
        misa[misa_i_bit] = 1'b1;
        misa[misa_a_bit] = misa_a;
        misa[misa_c_bit] = misa_c;
        misa[misa_m_bit] = misa_m;
    end

    // Fusion flags and fork bit stay zero.
    assign mimpid = {10'd0, 6'(div_latency), ver_major, ver_minor, ver_patch};
    // Only enabled sources show as pending.
    assign mip = irq_pending & mie;

    assign tvec    = mtvec;
    assign ret_epc = mepc;

    // Read data and access rights, decoded per address.
    always_comb begin
        csr_exists = 1'b1;
        csr_rdonly = 1'b0;
        csr_rdata  = '0;
        case (csr_addr)
            MSTATUS:    csr_rdata = mstatus;
            MISA:       csr_rdata = misa;
            MEDELEG:    csr_rdata = '0;
            MIDELEG:    csr_rdata = '0;
            MIE:        csr_rdata = mie;
            MTVEC:      csr_rdata = {mtvec, 2'b00};
            MSTATUSH:   csr_rdata = '0;
            MIP:        csr_rdata = mip;
            MSCRATCH:   csr_rdata = mscratch;
            MEPC:       csr_rdata = {mepc, 1'b0};
            MCAUSE:     csr_rdata = {mcause_int, 26'd0, mcause_no};
            MTVAL:      csr_rdata = '0;
            MVENDORID: begin
                csr_rdonly = 1'b1;
                csr_rdata  = '0;
            end
            MARCHID: begin
                csr_rdonly = 1'b1;
                csr_rdata  = arch_id;
            end
            MIMPID: begin
                csr_rdonly = 1'b1;
                csr_rdata  = mimpid;
            end
            MHARTID: begin
                csr_rdonly = 1'b1;
                csr_rdata  = hartid;
            end
            MCONFIGPTR: begin
                csr_rdonly = 1'b1;
                csr_rdata  = '0;
            end
            default:    csr_exists = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mie          <= '0;
            mtvec        <= '0;
            mscratch     <= '0;
            mepc         <= '0;
            mcause_int   <= 1'b0;
            mcause_no    <= '0;
            // Come up with every built extension enabled.
            misa_a       <= has_a;
            misa_c       <= has_c;
            misa_m       <= has_m;
        end else if (take_irq || take_trap) begin
            // Trap entry, stack the enable and mask further interrupts.
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0;
            mepc         <= take_epc;
            mcause_int   <= take_irq;
            mcause_no    <= take_cause;
        end else if (csr_we) begin
            // Read-only and unknown addresses fall through.
            case (csr_addr)
                MSTATUS: begin
                    mstatus_mie  <= csr_wdata[mstatus_mie_bit];
                    mstatus_mpie <= csr_wdata[mstatus_mpie_bit];
                end
                MISA: begin
                    if (misa_we) begin
                        misa_a <= has_a && csr_wdata[misa_a_bit];
                        misa_c <= has_c && csr_wdata[misa_c_bit];
                        misa_m <= has_m && csr_wdata[misa_m_bit];
                    end
                end
                MIE:      mie      <= csr_wdata;
                MTVEC:    mtvec    <= csr_wdata[31:2];
                MSCRATCH: mscratch <= csr_wdata;
                MEPC:     mepc     <= csr_wdata[31:1];
                MCAUSE: begin
                    mcause_int <= csr_wdata[31];
                    mcause_no  <= csr_wdata[4:0];
                end
                default: ;
            endcase
        end else if (mret) begin
            // Unstack the interrupt enable.
            mstatus_mie <= mstatus_mpie;
        end
    end

endmodule

// ==== verilog/irq_arbiter.sv ====
// Lines are sampled without synchronizers; lowest number wins; settle history has no reset.
module irq_arbiter import rv_csr_pkg::*; #(
    parameter int mie_settle = 2
) (
    input  logic         clk,
    input  logic         timer_irq,
    input  logic [31:16] irq,
    input  irq_vec_t     mie,
    input  logic         mstatus_mie,
    output irq_vec_t     irq_pending,
    output cause_t       irq_cause,
    output logic         irq_enabled
);
    // Pending lines that are also enabled.
    irq_vec_t              masked;
    // Past values of mstatus.MIE, newest in bit 0.
    logic [mie_settle-1:0] mie_hist;

    // One register stage for the lines.
    // Numbers without a source read zero.
    always_ff @(posedge clk) begin
        irq_pending                <= '0;
        irq_pending[31:ext_irq_lo] <= irq;
        irq_pending[timer_irq_num] <= timer_irq;
    end

    // MIE is clear through reset, so the history fills with zeros.
    always_ff @(posedge clk) begin
        mie_hist <= mie_settle'({mie_hist, mstatus_mie});
    end

    assign masked = irq_pending & mie;

    // Scan down so the lowest set number is left.
    // Zero means nothing to take.
    always_comb begin
        irq_cause = '0;
        for (int i = 31; i >= 0; i--) begin
            if (masked[i]) begin
                irq_cause = cause_t'(i);
            end
        end
    end

    // Enable must be stable now and over the whole window.
    assign irq_enabled = mstatus_mie && (&mie_hist);

endmodule

// ==== verilog/trap_dispatch.sv ====
// Combinational only; a trap request counts only on a retire cycle, interrupt beats trap.
module trap_dispatch import rv_csr_pkg::*; (
    input  logic   retire_valid,
    input  pc_t    retire_pc,
    input  logic   trap,
    input  cause_t trap_cause,
    input  cause_t irq_cause,
    input  logic   irq_enabled,
    output logic   take_irq,
    output logic   take_trap,
    output cause_t take_cause,
    output pc_t    take_epc,
    output logic   exception
);

    always_comb begin
        // Interrupt taken on a retiring instruction.
        take_irq  = retire_valid && irq_enabled && (irq_cause != '0);
        // Trap only when no interrupt claims the slot.
        take_trap = retire_valid && trap && !take_irq;

        if (take_irq) begin
            take_cause = irq_cause;
        end else begin
            take_cause = trap_cause;
        end

        // Saved PC is word aligned.
        take_epc = {retire_pc[31:2], 1'b0};

        // Redirect to the vector.
        exception = take_irq || take_trap;
    end

endmodule

// ==== verilog/trap_unit.sv ====
// Strobes come straight from writeback; redirect target is tvec, direct mode only.
module trap_unit import rv_csr_pkg::*; #(
    parameter xlen_word_t hartid      = 32'h0,
    parameter bit         misa_we     = 1'b1,
    parameter bit         has_m       = 1'b1,
    parameter bit         has_a       = 1'b1,
    parameter bit         has_c       = 1'b1,
    parameter int         div_latency = 2
) (
    input  logic         clk,
    input  logic         rst,
    // CSR access port.
    input  csr_addr_t    csr_addr,
    input  logic         csr_we,
    input  xlen_word_t   csr_wdata,
    output xlen_word_t   csr_rdata,
    output logic         csr_exists,
    output logic         csr_rdonly,
    // Writeback strobes.
    input  logic         retire_valid,
    input  pc_t          retire_pc,
    input  logic         trap,
    input  cause_t       trap_cause,
    input  logic         mret,
    // Interrupt lines.
    input  logic         timer_irq,
    input  logic [31:16] irq,
    // Redirect and status.
    output logic         exception,
    output tvec_t        tvec,
    output pc_t          ret_epc,
    output xlen_word_t   misa
);
    // CSR state toward the arbiter.
    logic     mstatus_mie;
    irq_vec_t mie;
    // Arbiter results.
    irq_vec_t irq_pending;
    cause_t   irq_cause;
    logic     irq_enabled;
    // Dispatch decision.
    logic     take_irq;
    logic     take_trap;
    cause_t   take_cause;
    pc_t      take_epc;

    machine_csrs #(
        .hartid      (hartid),
        .misa_we     (misa_we),
        .has_m       (has_m),
        .has_a       (has_a),
        .has_c       (has_c),
        .div_latency (div_latency)
    ) csrs_i (
        .clk         (clk),
        .rst         (rst),
        .csr_addr    (csr_addr),
        .csr_we      (csr_we),
        .csr_wdata   (csr_wdata),
        .take_irq    (take_irq),
        .take_trap   (take_trap),
        .take_cause  (take_cause),
        .take_epc    (take_epc),
        .mret        (mret),
        .irq_pending (irq_pending),
        .csr_rdata   (csr_rdata),
        .csr_exists  (csr_exists),
        .csr_rdonly  (csr_rdonly),
        .mstatus_mie (mstatus_mie),
        .mie         (mie),
        .tvec        (tvec),
        .ret_epc     (ret_epc),
        .misa        (misa)
    );

    irq_arbiter arbiter_i (
        .clk         (clk),
        .timer_irq   (timer_irq),
        .irq         (irq),
        .mie         (mie),
        .mstatus_mie (mstatus_mie),
        .irq_pending (irq_pending),
        .irq_cause   (irq_cause),
        .irq_enabled (irq_enabled)
    );

    trap_dispatch dispatch_i (
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .trap         (trap),
        .trap_cause   (trap_cause),
        .irq_cause    (irq_cause),
        .irq_enabled  (irq_enabled),
        .take_irq     (take_irq),
        .take_trap    (take_trap),
        .take_cause   (take_cause),
        .take_epc     (take_epc),
        .exception    (exception)
    );

endmodule

// ==== dv/trap_unit_assertions.sv ====
// Checks only outside reset; mstatus_mie is the internal CSR bit reached through bind.
module trap_unit_assertions (
    input logic clk,
    input logic rst,
    input logic exception,
    input logic trap,
    input logic retire_valid,
    input logic mstatus_mie
);

    // Redirect must always be a known level.
    exception_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(exception))
        else $error("exception is unknown");

    // A trap request counts only on a retire cycle.
    trap_needs_retire: assert property (@(posedge clk) disable iff (rst)
        (trap && !retire_valid) |-> !exception)
        else $error("exception raised by trap without retire_valid");

    // Entry masks further interrupts.
    mie_cleared_on_entry: assert property (@(posedge clk) disable iff (rst)
        exception |=> !mstatus_mie)
        else $error("mstatus.MIE still set after exception");

endmodule

bind trap_unit trap_unit_assertions assertions_i (.*);

// ==== dv/trap_unit_tb.sv ====
// One hart with every extension built and misa writable; the run stops at the first mismatch.
module trap_unit_tb
    import rv_csr_pkg::*;
    import impl_id_pkg::*;
();
    localparam xlen_word_t tb_hartid      = 32'h0000_0003;
    localparam int         tb_div_latency = 5;
    // All tests need under 100 cycles.
    localparam int         max_cycles     = 400;
    // PC of the trapping instruction, bit 1 set.
    localparam xlen_word_t trap_pc        = 32'h0000_4a6e;

    logic         clk;
    logic         rst;
    csr_addr_t    csr_addr;
    logic         csr_we;
    xlen_word_t   csr_wdata;
    xlen_word_t   csr_rdata;
    logic         csr_exists;
    logic         csr_rdonly;
    logic         retire_valid;
    pc_t          retire_pc;
    logic         trap;
    cause_t       trap_cause;
    logic         mret;
    logic         timer_irq;
    logic [31:16] irq;
    logic         exception;
    tvec_t        tvec;
    pc_t          ret_epc;
    xlen_word_t   misa;

    integer seed;
    int     cycles = 0;

    trap_unit #(
        .hartid      (tb_hartid),
        .misa_we     (1'b1),
        .has_m       (1'b1),
        .has_a       (1'b1),
        .has_c       (1'b1),
        .div_latency (tb_div_latency)
    ) trap_unit_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("Timeout: tests still running after %0d cycles", cycles);
            report_failure();
        end
    end

    task automatic report_failure();
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input xlen_word_t got, input xlen_word_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_pc(input string name, input pc_t got, input pc_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            report_failure();
        end
    endtask

    // Drive point, just after the rising edge.
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic csr_write(input csr_addr_t addr, input xlen_word_t data);
        next_cycle();
        csr_addr  = addr;
        csr_we    = 1'b1;
        csr_wdata = data;
        next_cycle();
        csr_we = 1'b0;
    endtask

    // Read data settles within the cycle.
    task automatic csr_read(input csr_addr_t addr, output xlen_word_t data);
        next_cycle();
        csr_addr = addr;
        #1;
        data = csr_rdata;
    endtask

    // MXL 32 with I, M, A and C.
    function automatic xlen_word_t expected_misa();
        xlen_word_t exp;
        exp = '0;
        exp[31:30]        = misa_mxl_32;
        exp[misa_i_bit]   = 1'b1;
        exp[misa_m_bit]   = 1'b1;
        exp[misa_a_bit]   = 1'b1;
        exp[misa_c_bit]   = 1'b1;
        return exp;
    endfunction

    task automatic read_reset_values();
        csr_addr_t  zero_regs[6] = '{MSTATUS, MIE, MTVEC, MEPC, MCAUSE, MSCRATCH};
        csr_addr_t  id_regs[5]   = '{MVENDORID, MARCHID, MIMPID, MHARTID, MCONFIGPTR};
        xlen_word_t exp_impid;
        xlen_word_t data;
        // Version in the low half, divider latency above it.
        exp_impid        = '0;
        exp_impid[3:0]   = ver_patch;
        exp_impid[7:4]   = ver_minor;
        exp_impid[15:8]  = ver_major;
        exp_impid[21:16] = 6'(tb_div_latency);
        foreach (zero_regs[i]) begin
            csr_read(zero_regs[i], data);
            check_word($sformatf("csr_rdata at %h", zero_regs[i]), data, '0);
        end
        check_bit("exception", exception, 1'b0);
        csr_read(MISA, data);
        check_word("misa read", data, expected_misa());
        check_word("misa", misa, expected_misa());
        csr_read(MARCHID, data);
        check_word("marchid", data, arch_id);
        csr_read(MHARTID, data);
        check_word("mhartid", data, tb_hartid);
        csr_read(MIMPID, data);
        check_word("mimpid", data, exp_impid);
        // Custom space, nothing lives here.
        csr_read(12'h7c0, data);
        check_bit("csr_exists", csr_exists, 1'b0);
        foreach (id_regs[i]) begin
            csr_read(id_regs[i], data);
            check_bit($sformatf("csr_rdonly at %h", id_regs[i]), csr_rdonly, 1'b1);
        end
    endtask

    task automatic write_and_read_back();
        csr_addr_t  addrs[4] = '{MSCRATCH, MIE, MTVEC, MEPC};
        string      names[4] = '{"mscratch", "mie", "mtvec", "mepc"};
        // Alignment bits that read zero.
        xlen_word_t masks[4] = '{32'hffff_ffff, 32'hffff_ffff, 32'hffff_fffc, 32'hffff_fffe};
        xlen_word_t val;
        xlen_word_t data;
        foreach (addrs[i]) begin
            val = $random(seed);
            csr_write(addrs[i], val);
            csr_read(addrs[i], data);
            check_word(names[i], data, val & masks[i]);
        end
        val = $random(seed);
        csr_write(MARCHID, val);
        csr_read(MARCHID, data);
        check_word("marchid", data, arch_id);
        csr_write(MIE, '0);
    endtask

    task automatic enter_trap();
        xlen_word_t vec_base = 32'h0000_1200;
        xlen_word_t data;
        csr_write(MTVEC, vec_base);
        csr_write(MSTATUS, 32'h1 << mstatus_mie_bit);
        // Request with no retiring instruction is ignored.
        next_cycle();
        trap       = 1'b1;
        trap_cause = 5'd2;
        #1;
        check_bit("exception", exception, 1'b0);
        next_cycle();
        retire_valid = 1'b1;
        retire_pc    = trap_pc[31:1];
        #1;
        check_bit("exception", exception, 1'b1);
        check_word("tvec", {tvec, 2'b00}, vec_base);
        next_cycle();
        retire_valid = 1'b0;
        trap         = 1'b0;
        csr_read(MEPC, data);
        // Bit 1 of the PC is dropped.
        check_word("mepc", data, trap_pc & ~32'h2);
        csr_read(MCAUSE, data);
        check_word("mcause", data, 32'd2);
        csr_read(MSTATUS, data);
        check_bit("mstatus.mie", data[mstatus_mie_bit], 1'b0);
        check_bit("mstatus.mpie", data[mstatus_mpie_bit], 1'b1);
    endtask

    task automatic return_from_trap();
        xlen_word_t epc;
        xlen_word_t data;
        epc = trap_pc & ~32'h2;
        next_cycle();
        mret = 1'b1;
        #1;
        check_pc("ret_epc", ret_epc, epc[31:1]);
        next_cycle();
        mret = 1'b0;
        csr_read(MSTATUS, data);
        check_bit("mstatus.mie", data[mstatus_mie_bit], 1'b1);
    endtask

    task automatic take_priority_irq();
        xlen_word_t enables;
        xlen_word_t data;
        int         waited;
        enables = (32'h1 << timer_irq_num) | (32'h1 << 20);
        csr_write(MIE, enables);
        csr_write(MSTATUS, 32'h1 << mstatus_mie_bit);
        next_cycle();
        timer_irq    = 1'b1;
        irq[20]      = 1'b1;
        retire_valid = 1'b1;
        retire_pc    = 31'h0000_2100;
        waited       = 0;
        #1;
        while (!exception && waited < 10) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (!exception) begin
            $display("Interrupt was not taken within 10 cycles");
            report_failure();
        end
        next_cycle();
        retire_valid = 1'b0;
        // Timer is the lower number.
        csr_read(MCAUSE, data);
        check_word("mcause", data, 32'h8000_0007);
        csr_read(MIP, data);
        check_word("mip", data, enables);
        // Entry cleared MIE, lines still high.
        next_cycle();
        retire_valid = 1'b1;
        repeat (6) begin
            #1;
            check_bit("exception", exception, 1'b0);
            next_cycle();
        end
        // MIE set again, held off for two edges.
        csr_write(MSTATUS, 32'h1 << mstatus_mie_bit);
        repeat (2) begin
            #1;
            check_bit("exception", exception, 1'b0);
            next_cycle();
        end
        #1;
        check_bit("exception", exception, 1'b1);
        next_cycle();
        retire_valid = 1'b0;
        timer_irq    = 1'b0;
        irq          = '0;
    endtask

    task automatic toggle_misa_c();
        xlen_word_t no_c;
        xlen_word_t data;
        no_c = expected_misa() & ~(32'h1 << misa_c_bit);
        csr_write(MISA, no_c);
        csr_read(MISA, data);
        check_word("misa read", data, no_c);
        check_bit("misa.c", misa[misa_c_bit], 1'b0);
        csr_write(MISA, expected_misa());
        csr_read(MISA, data);
        check_word("misa read", data, expected_misa());
    endtask

    initial begin
        seed         = 32'hf3e5;
        rst          = 1'b1;
        csr_addr     = '0;
        csr_we       = 1'b0;
        csr_wdata    = '0;
        retire_valid = 1'b0;
        retire_pc    = '0;
        trap         = 1'b0;
        trap_cause   = '0;
        mret         = 1'b0;
        timer_irq    = 1'b0;
        irq          = '0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        read_reset_values();
        write_and_read_back();
        enter_trap();
        return_from_trap();
        take_priority_irq();
        toggle_misa_c();
        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== sources.f ====
verilog/rv_csr_pkg.sv
verilog/impl_id_pkg.sv
verilog/machine_csrs.sv
verilog/irq_arbiter.sv
verilog/trap_dispatch.sv
verilog/trap_unit.sv
dv/trap_unit_assertions.sv
dv/trap_unit_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?=
TOP       ?= trap_unit_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Simulation failed

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --binary --timing --assert --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Run failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
